// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := exec_alu_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/alu_basic.sv
`timescale 1ns/1ps
`default_nettype none

module alu_basic (
    input  alu_pkg::alu_op_e         op,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    input  logic                     word_shift,
    output logic [alu_pkg::xlen-1:0] y
);
    import alu_pkg::*;

    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    a_word_sext;
    logic [xlen-1:0]    sra_full;
    logic [xlen-1:0]    sra_word;

    assign shamt = b[shamt_w-1:0];

    // 32-bit form sign-extends the low word first and keeps the low word
    assign a_word_sext = {{(xlen/2){a[xlen/2-1]}}, a[xlen/2-1:0]};
    assign sra_word    = $signed(a_word_sext) >>> shamt;
    assign sra_full    = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            op_add:    y = a + b;
            op_sub:    y = a - b;
            op_pass_a: y = a;
            op_pass_b: y = b;
            op_xor:    y = a ^ b;
            op_or:     y = a | b;
            op_and:    y = a & b;
            op_sll:    y = a << shamt;
            op_srl:    y = a >> shamt;
            op_sra: begin
                if (word_shift) begin
                    y = {{(xlen/2){1'b0}}, sra_word[xlen/2-1:0]};
                end else begin
                    y = sra_full;
                end
            end
            // comparisons give 0 or 1
            op_slt:    y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu:   y = {{(xlen-1){1'b0}}, a < b};
            op_eq:     y = {{(xlen-1){1'b0}}, a == b};
            op_ge:     y = {{(xlen-1){1'b0}}, $signed(a) >= $signed(b)};
            op_geu:    y = {{(xlen-1){1'b0}}, a >= b};
            // mul and div results come from the iterative units
            default:   y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // datapath width and shift amount width
    localparam int xlen    = 64;
    localparam int shamt_w = 6;

    // iteration counts of the multi-cycle units
    localparam int mul_steps = 32;
    localparam int div_steps = 64;

    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_e;

    typedef enum logic [0:0] {
        src_a_pc  = 1'b0,
        src_a_rs1 = 1'b1
    } src_a_e;

    typedef enum logic [1:0] {
        src_b_imm = 2'd0,
        src_b_rs2 = 2'd1,
        src_b_csr = 2'd2
    } src_b_e;

endpackage

`default_nettype wire

// File: logic/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     issue,
    input  alu_pkg::alu_op_e         operate,
    input  logic [alu_pkg::xlen-1:0] pc,
    input  logic [alu_pkg::xlen-1:0] rs1,
    input  logic [alu_pkg::xlen-1:0] rs2,
    input  logic [alu_pkg::xlen-1:0] csr,
    input  logic [alu_pkg::xlen-1:0] imm,
    input  alu_pkg::src_a_e          sel_a,
    input  alu_pkg::src_b_e          sel_b,
    input  logic                     rs1to32,
    output logic [alu_pkg::xlen-1:0] res,
    output logic                     res_valid,
    output logic                     alu_wait
);
    import alu_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] basic_y;
    logic [xlen-1:0] mul_product;
    logic [xlen-1:0] div_result;
    logic            mul_done;
    logic            div_done;
    logic            accept;
    logic            is_mul;
    logic            is_div;
    logic            mul_start;
    logic            div_start;
    logic            div_signed;
    logic            div_rem;

    operand_select operand_select_inst (
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .rs1to32 (rs1to32),
        .a       (a),
        .b       (b)
    );

    alu_basic alu_basic_inst (
        .op         (operate),
        .a          (a),
        .b          (b),
        .word_shift (rs1to32),
        .y          (basic_y)
    );

    // issue while busy is dropped
    assign accept = issue && !alu_wait;

    assign is_mul     = (operate == op_mul);
    assign is_div     = (operate inside {op_div, op_divu, op_rem, op_remu});
    assign mul_start  = accept && is_mul;
    assign div_start  = accept && is_div;
    assign div_signed = (operate == op_div) || (operate == op_rem);
    assign div_rem    = (operate == op_rem) || (operate == op_remu);

    seq_multiplier seq_multiplier_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .start   (mul_start),
        .a       (a),
        .b       (b),
        .done    (mul_done),
        .product (mul_product)
    );

    seq_divider seq_divider_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .start     (div_start),
        .a         (a),
        .b         (b),
        .is_signed (div_signed),
        .want_rem  (div_rem),
        .done      (div_done),
        .result    (div_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res       <= '0;
            res_valid <= 1'b0;
            alu_wait  <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (flush) begin
                // abandon whatever is in flight
                alu_wait <= 1'b0;
            end else if (alu_wait) begin
                if (mul_done || div_done) begin
                    res       <= mul_done ? mul_product : div_result;
                    res_valid <= 1'b1;
                    alu_wait  <= 1'b0;
                end
            end else if (accept) begin
                if (is_mul || is_div) begin
                    alu_wait <= 1'b1;
                end else begin
                    res       <= basic_y;
                    res_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  logic [alu_pkg::xlen-1:0] pc,
    input  logic [alu_pkg::xlen-1:0] rs1,
    input  logic [alu_pkg::xlen-1:0] rs2,
    input  logic [alu_pkg::xlen-1:0] csr,
    input  logic [alu_pkg::xlen-1:0] imm,
    input  alu_pkg::src_a_e          sel_a,
    input  alu_pkg::src_b_e          sel_b,
    input  logic                     rs1to32,
    output logic [alu_pkg::xlen-1:0] a,
    output logic [alu_pkg::xlen-1:0] b
);
    import alu_pkg::*;

    logic [xlen-1:0] rs1_ext;

    // word ops see only the low half of rs1
    assign rs1_ext = rs1to32 ? {{(xlen/2){1'b0}}, rs1[xlen/2-1:0]} : rs1;

    assign a = (sel_a == src_a_rs1) ? rs1_ext : pc;

    always_comb begin
        case (sel_b)
            src_b_rs2: b = rs2;
            src_b_csr: b = csr;
            default:   b = imm;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

module seq_divider (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     start,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    input  logic                     is_signed,
    input  logic                     want_rem,
    output logic                     done,
    output logic [alu_pkg::xlen-1:0] result
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix
    } div_state_e;

    div_state_e                     state;
    logic [$clog2(div_steps)-1:0]   cnt;
    logic [xlen-1:0]                quo;
    logic [xlen-1:0]                rem;
    logic [xlen-1:0]                divisor;
    logic                           neg_q;
    logic                           neg_r;
    logic                           rem_sel;
    logic [xlen-1:0]                a_mag;
    logic [xlen-1:0]                b_mag;
    logic                           div_zero;
    logic                           overflow;
    logic [xlen:0]                  shifted;
    logic [xlen:0]                  diff;

    assign a_mag = (is_signed && a[xlen-1]) ? -a : a;
    assign b_mag = (is_signed && b[xlen-1]) ? -b : b;

    // corner cases resolved at start
    assign div_zero = (b == '0);
    assign overflow = is_signed && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);

    // one restoring step shifts in the next dividend bit and tries to subtract
    assign shifted = {rem, quo[xlen-1]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                state <= st_idle;
                cnt   <= '0;
            end else begin
                case (state)
                    st_idle: begin
                        if (start) begin
                            state <= (div_zero || overflow) ? st_fix : st_run;
                            cnt   <= '0;
                        end
                    end
                    st_run: begin
                        cnt <= cnt + 1'b1;
                        if (cnt == div_steps - 1) begin
                            state <= st_fix;
                        end
                    end
                    st_fix: begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            rem_sel <= want_rem;
            divisor <= b_mag;
            if (div_zero) begin
                quo   <= '1;
                rem   <= a;
                neg_q <= 1'b0;
                neg_r <= 1'b0;
            end else if (overflow) begin
                quo   <= a;
                rem   <= '0;
                neg_q <= 1'b0;
                neg_r <= 1'b0;
            end else begin
                quo   <= a_mag;
                rem   <= '0;
                neg_q <= is_signed && (a[xlen-1] ^ b[xlen-1]);
                neg_r <= is_signed && a[xlen-1];
            end
        end else if (state == st_run) begin
            if (!diff[xlen]) begin
                rem <= diff[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= shifted[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end else if (state == st_fix) begin
            // quotient and remainder take the signs of the operands
            if (rem_sel) begin
                result <= neg_r ? -rem : rem;
            end else begin
                result <= neg_q ? -quo : quo;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     start,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    output logic                     done,
    output logic [alu_pkg::xlen-1:0] product
);
    import alu_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } mul_state_e;

    mul_state_e                       state;
    logic [$clog2(mul_steps+1)-1:0]   cnt;
    logic [xlen-1:0]                  mcand;
    logic [xlen-1:0]                  mplier;
    logic [xlen-1:0]                  acc;
    logic [xlen-1:0]                  partial;

    // radix-4 digit picks 0, 1, 2 or 3 times the multiplicand
    always_comb begin
        case (mplier[1:0])
            2'd1:    partial = mcand;
            2'd2:    partial = mcand << 1;
            2'd3:    partial = mcand + (mcand << 1);
            default: partial = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                state <= st_idle;
                cnt   <= '0;
            end else if (state == st_idle) begin
                if (start) begin
                    state <= st_run;
                    cnt   <= '0;
                end
            end else if (cnt == mul_steps) begin
                // acc holds the low product bits once all digits are consumed
                done  <= 1'b1;
                state <= st_idle;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // load on start, then one radix-4 digit per step
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == st_run && cnt != mul_steps) begin
            acc    <= acc + partial;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// File: sim.f
logic/alu_pkg.sv
logic/operand_select.sv
logic/alu_basic.sv
logic/seq_multiplier.sv
logic/seq_divider.sv
logic/exec_alu.sv
tb/exec_alu_assertions.sv
tb/exec_alu_tb.sv

// File: tb/exec_alu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu_assertions (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic issue,
    input logic alu_wait,
    input logic res_valid
);

    // result strobe is a single-cycle pulse
    res_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |=> !res_valid)
        else $error("res_valid high for two cycles in a row");

    // upstream must hold off while busy
    no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> !alu_wait)
        else $error("issue arrived while alu_wait was high");

    flush_clears_wait: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !alu_wait)
        else $error("alu_wait not low on the edge after flush");

endmodule

bind exec_alu exec_alu_assertions exec_alu_assertions_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .issue     (issue),
    .alu_wait  (alu_wait),
    .res_valid (res_valid)
);

`default_nettype wire

// File: tb/exec_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu_tb;
    import alu_pkg::*;

    typedef struct packed {
        alu_op_e         op;
        src_a_e          sa;
        src_b_e          sb;
        logic            w;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] csr;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] expect_res;
    } row_t;

    localparam logic [xlen-1:0] min_neg = {1'b1, {(xlen-1){1'b0}}};
    localparam int wait_limit = div_steps + 10;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            issue;
    alu_op_e         operate;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr;
    logic [xlen-1:0] imm;
    src_a_e          sel_a;
    src_b_e          sel_b;
    logic            rs1to32;
    logic [xlen-1:0] res;
    logic            res_valid;
    logic            alu_wait;

    row_t   rows[$];
    int     errors;
    int     checks;
    longint watchdog_ns;

    exec_alu exec_alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .issue     (issue),
        .operate   (operate),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .res       (res),
        .res_valid (res_valid),
        .alu_wait  (alu_wait)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [xlen-1:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // reference behavior of the execute unit, written from the ISA rules
    function automatic logic [xlen-1:0] model_result(input row_t r);
        logic [xlen-1:0]        x;
        logic [xlen-1:0]        y;
        logic signed [xlen-1:0] xs;
        logic signed [xlen-1:0] ys;
        logic [31:0]            lo;
        logic [xlen-1:0]        res_m;
        int                     sh;
        if (r.sa == src_a_pc) begin
            x = r.pc;
        end else if (r.w) begin
            x = {32'h0, r.rs1[31:0]};
        end else begin
            x = r.rs1;
        end
        case (r.sb)
            src_b_rs2: y = r.rs2;
            src_b_csr: y = r.csr;
            default:   y = r.imm;
        endcase
        xs = x;
        ys = y;
        sh = int'(y[5:0]);
        case (r.op)
            op_add:    res_m = x + y;
            op_sub:    res_m = x - y;
            op_pass_a: res_m = x;
            op_pass_b: res_m = y;
            op_xor:    res_m = x ^ y;
            op_or:     res_m = x | y;
            op_and:    res_m = x & y;
            op_sll:    res_m = x << sh;
            op_srl:    res_m = x >> sh;
            op_sra: begin
                if (!r.w) begin
                    res_m = xs >>> sh;
                end else begin
                    // shifting past the word leaves only sign bits
                    if (sh >= 32) begin
                        lo = {32{x[31]}};
                    end else begin
                        lo = $signed(x[31:0]) >>> sh;
                    end
                    res_m = {32'h0, lo};
                end
            end
            op_slt:    res_m = (xs < ys) ? 64'd1 : 64'd0;
            op_sltu:   res_m = (x < y) ? 64'd1 : 64'd0;
            op_eq:     res_m = (x == y) ? 64'd1 : 64'd0;
            op_ge:     res_m = (xs >= ys) ? 64'd1 : 64'd0;
            op_geu:    res_m = (x >= y) ? 64'd1 : 64'd0;
            op_mul:    res_m = x * y;
            op_div: begin
                if (y == '0) res_m = '1;
                else if (x == min_neg && y == '1) res_m = min_neg;
                else res_m = xs / ys;
            end
            op_divu:   res_m = (y == '0) ? '1 : x / y;
            op_rem: begin
                if (y == '0) res_m = x;
                else if (x == min_neg && y == '1) res_m = '0;
                else res_m = xs % ys;
            end
            op_remu:   res_m = (y == '0) ? x : x % y;
            default:   res_m = '0;
        endcase
        return res_m;
    endfunction

    function automatic row_t make_row(input alu_op_e op, input src_a_e sa, input src_b_e sb,
                                      input logic w, input logic [xlen-1:0] rs1_v,
                                      input logic [xlen-1:0] rs2_v,
                                      input logic [xlen-1:0] exp_res, input logic use_model);
        row_t r;
        r.op  = op;
        r.sa  = sa;
        r.sb  = sb;
        r.w   = w;
        r.pc  = rand64();
        r.rs1 = rs1_v;
        r.rs2 = rs2_v;
        r.csr = rand64();
        r.imm = rand64();
        r.expect_res = use_model ? model_result(r) : exp_res;
        return r;
    endfunction

    task automatic add_expected(input alu_op_e op, input logic w, input logic [xlen-1:0] a_v,
                                input logic [xlen-1:0] b_v, input logic [xlen-1:0] exp_res);
        rows.push_back(make_row(op, src_a_rs1, src_b_rs2, w, a_v, b_v, exp_res, 1'b0));
    endtask

    task automatic add_modeled(input alu_op_e op, input src_a_e sa, input src_b_e sb,
                               input logic w, input logic [xlen-1:0] a_v,
                               input logic [xlen-1:0] b_v);
        rows.push_back(make_row(op, sa, sb, w, a_v, b_v, '0, 1'b1));
    endtask

    task automatic build_table();
        // every single-cycle op from every source pair
        for (int k = 0; k <= int'(op_geu); k++) begin
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < 3; j++) begin
                    add_modeled(alu_op_e'(k), src_a_e'(i), src_b_e'(j), 1'b0, rand64(), rand64());
                end
            end
        end
        // equal operands
        add_expected(op_eq, 1'b1, 64'hffff_ffff_1234_5678, 64'h0000_0000_1234_5678, 64'd1);
        add_expected(op_ge, 1'b0, 64'h8765_4321_0fed_cba9, 64'h8765_4321_0fed_cba9, 64'd1);
        add_expected(op_geu, 1'b0, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 64'd1);
        // word forms
        add_expected(op_add, 1'b1, 64'hffff_ffff_8000_0001, 64'd1, 64'h0000_0000_8000_0002);
        add_expected(op_pass_a, 1'b1, 64'hdead_beef_1234_5678, 64'd0, 64'h0000_0000_1234_5678);
        add_expected(op_sra, 1'b1, 64'h1234_5678_8000_0000, 64'd4, 64'h0000_0000_f800_0000);
        add_expected(op_sra, 1'b1, 64'hffff_ffff_7000_0000, 64'd4, 64'h0000_0000_0700_0000);
        add_expected(op_sra, 1'b1, 64'h0000_0000_8000_0000, 64'd40, 64'h0000_0000_ffff_ffff);
        add_expected(op_sra, 1'b0, min_neg, 64'd63, '1);
        for (int i = 0; i < 6; i++) begin
            add_modeled(op_sra, src_a_rs1, src_b_rs2, 1'b1, rand64(), rand64());
            add_modeled(op_srl, src_a_rs1, src_b_imm, 1'b1, rand64(), rand64());
        end
        // multiplier extremes
        add_expected(op_mul, 1'b0, '1, '1, 64'd1);
        add_expected(op_mul, 1'b0, min_neg, 64'd2, 64'd0);
        add_expected(op_mul, 1'b0, '1, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0001);
        add_expected(op_mul, 1'b0, 64'h1_0000_0000, 64'h1_0000_0000, 64'd0);
        add_expected(op_mul, 1'b0, 64'd0, 64'h1234_5678_9abc_def0, 64'd0);
        for (int i = 0; i < 8; i++) begin
            add_modeled(op_mul, src_a_rs1, src_b_rs2, 1'b0, rand64(), rand64());
        end
        // divide by zero and signed overflow
        add_expected(op_div, 1'b0, 64'd123, 64'd0, '1);
        add_expected(op_divu, 1'b0, 64'd123, 64'd0, '1);
        add_expected(op_rem, 1'b0, 64'd123, 64'd0, 64'd123);
        add_expected(op_remu, 1'b0, 64'd123, 64'd0, 64'd123);
        add_expected(op_div, 1'b0, min_neg, '1, min_neg);
        add_expected(op_rem, 1'b0, min_neg, '1, 64'd0);
        add_expected(op_divu, 1'b0, min_neg, '1, 64'd0);
        add_expected(op_remu, 1'b0, min_neg, '1, min_neg);
        add_expected(op_div, 1'b0, 64'hffff_ffff_ffff_fff9, 64'd2, 64'hffff_ffff_ffff_fffd);
        add_expected(op_rem, 1'b0, 64'hffff_ffff_ffff_fff9, 64'd2, '1);
        add_expected(op_div, 1'b0, 64'd100, 64'hffff_ffff_ffff_fff9, 64'hffff_ffff_ffff_fff2);
        add_expected(op_rem, 1'b0, 64'd100, 64'hffff_ffff_ffff_fff9, 64'd2);
        add_expected(op_divu, 1'b0, '1, min_neg, 64'd1);
        add_expected(op_remu, 1'b0, '1, min_neg, 64'h7fff_ffff_ffff_ffff);
        for (int k = int'(op_div); k <= int'(op_remu); k++) begin
            for (int i = 0; i < 6; i++) begin
                // half the divisors are small so the quotient is wide
                add_modeled(alu_op_e'(k), src_a_rs1, src_b_rs2, 1'b0, rand64(),
                            (i % 2 == 0) ? rand64() : {32'h0, $urandom()});
            end
        end
    endtask

    task automatic apply_row(input int idx, input row_t r);
        int   cycles;
        logic multi;
        multi   = r.op inside {op_mul, op_div, op_divu, op_rem, op_remu};
        operate = r.op;
        sel_a   = r.sa;
        sel_b   = r.sb;
        rs1to32 = r.w;
        pc      = r.pc;
        rs1     = r.rs1;
        rs2     = r.rs2;
        csr     = r.csr;
        imm     = r.imm;
        issue   = 1'b1;
        @(posedge clk);
        #1;
        issue  = 1'b0;
        cycles = 0;
        if (!multi) begin
            assert (res_valid && !alu_wait) else begin
                $display("row %0d: %s gave no res_valid one cycle after issue, or raised alu_wait",
                         idx, r.op.name());
                errors++;
            end
        end
        while (!res_valid && cycles < wait_limit) begin
            if (multi) begin
                assert (alu_wait) else begin
                    $display("row %0d: alu_wait low before res_valid at %0t", idx, $time);
                    errors++;
                end
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!res_valid) begin
            $display("row %0d: no res_valid for %s within %0d cycles", idx, r.op.name(), cycles);
            errors++;
        end else begin
            assert (!alu_wait) else begin
                $display("row %0d: alu_wait still high when res_valid pulsed", idx);
                errors++;
            end
            assert (res == r.expect_res) else begin
                $display("error t=%0t res expected %h got %h (row %0d, %s)",
                         $time, r.expect_res, res, idx, r.op.name());
                errors++;
            end
        end
        checks++;
        // one idle cycle keeps res_valid a single pulse
        @(posedge clk);
        #1;
    endtask

    task automatic flush_during_divide();
        int stray;
        operate = op_div;
        sel_a   = src_a_rs1;
        sel_b   = src_b_rs2;
        rs1to32 = 1'b0;
        rs1     = 64'd1000;
        rs2     = 64'd7;
        issue   = 1'b1;
        @(posedge clk);
        #1;
        issue = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        assert (alu_wait) else begin
            $display("alu_wait was not high while the divide ran");
            errors++;
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        assert (!alu_wait) else begin
            $display("alu_wait still high one cycle after flush");
            errors++;
        end
        stray = 0;
        repeat (wait_limit) begin
            if (res_valid) stray++;
            @(posedge clk);
            #1;
        end
        assert (stray == 0) else begin
            $display("res_valid pulsed %0d times after the divide was flushed", stray);
            errors++;
        end
        checks++;
    endtask

    initial begin
        void'($urandom(42));
        rst_n   = 1'b0;
        flush   = 1'b0;
        issue   = 1'b0;
        operate = op_add;
        sel_a   = src_a_rs1;
        sel_b   = src_b_rs2;
        rs1to32 = 1'b0;
        pc      = '0;
        rs1     = '0;
        rs2     = '0;
        csr     = '0;
        imm     = '0;
        errors  = 0;
        checks  = 0;
        build_table();
        // the flush test and the add after it count as two more rows
        watchdog_ns = longint'(rows.size() + 2) * (div_steps + 10) * 4;
        fork
            begin
                #(watchdog_ns);
                $display("timeout: run did not finish within %0d ns", watchdog_ns);
                $display("Testbench failed");
                $finish;
            end
        join_none
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (res == '0 && !res_valid && !alu_wait) else begin
            $display("outputs not cleared by reset");
            errors++;
        end
        foreach (rows[i]) begin
            apply_row(i, rows[i]);
        end
        flush_during_divide();
        apply_row(rows.size(), make_row(op_add, src_a_rs1, src_b_rs2, 1'b0, 64'd40, 64'd2,
                                        64'd42, 1'b0));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
